// ==== common/gmii_line_pkg.sv ====
`default_nettype none

package gmii_line_pkg;

    localparam int BYTE_W = 8;

    // line symbols ahead of the frame body
    localparam logic [7:0] PREAMBLE_BYTE = 8'h55;
    localparam logic [7:0] SFD_BYTE      = 8'hD5;

    localparam int PREAMBLE_LEN = 7;
    localparam int FCS_LEN      = 4;
    localparam int IPG_CYCLES   = 12;

    // reflected form, shifts toward bit 0
    localparam logic [31:0] CRC_INIT      = 32'hFFFF_FFFF;
    localparam logic [31:0] CRC_POLY_REFL = 32'hEDB8_8320;

    typedef enum logic [2:0] {
        IDLE,
        PREAMBLE,
        SFD,
        BODY,
        FCS,
        GAP
    } tx_state_e;

endpackage

`default_nettype wire

// ==== common/mac_frame_pkg.sv ====
`default_nettype none

package mac_frame_pkg;

    localparam int WORD_W     = 64;
    localparam int WORD_BYTES = 8;

    // buffer depth doubles as the host's starting credit
    localparam int BUF_WORDS = 32;
    localparam int BUF_PTR_W = $clog2(BUF_WORDS);
    localparam int BUF_CNT_W = $clog2(BUF_WORDS + 1);

    localparam logic [47:0] PAUSE_DA        = 48'h01_80_C2_00_00_01;
    localparam logic [15:0] PAUSE_ETHERTYPE = 16'h8808;
    localparam logic [15:0] PAUSE_OPCODE    = 16'h0001;

    // da, sa, type, opcode, quanta
    localparam int PAUSE_HDR_LEN  = 18;
    localparam int PAUSE_BODY_LEN = 60;
    localparam int PAUSE_IDX_W    = $clog2(PAUSE_BODY_LEN);

    localparam int MAX_FRAME_BYTES = 256;

    typedef logic [3:0] byte_count_t;

endpackage

`default_nettype wire

// ==== common/byte_stream_if.sv ====
`timescale 1ns/10ps
`default_nettype none

interface byte_stream_if
    import gmii_line_pkg::*;
();

    logic              valid;
    logic [BYTE_W-1:0] data;
    logic              last;
    logic              ready;

    modport source (
        output valid, data, last,
        input  ready
    );

    modport sink (
        input  valid, data, last,
        output ready
    );

endinterface

`default_nettype wire

// ==== tx_framer/crc32_engine.sv ====
`timescale 1ns/10ps
`default_nettype none

module crc32_engine
    import gmii_line_pkg::*;
(
    input  wire               tx_clk,
    input  wire               rst_n,
    input  wire               clear,
    input  wire               enable,
    input  wire  [BYTE_W-1:0] data,
    output logic [31:0]       fcs
);

    logic [31:0] crc;

    // one byte, lsb first
    function automatic logic [31:0] crc_byte(input logic [31:0] crc_in,
                                             input logic [BYTE_W-1:0] d);
        logic [31:0] c;
        c = crc_in;
        for (int i = 0; i < BYTE_W; i++) begin
            c = (c >> 1) ^ (CRC_POLY_REFL & {32{c[0] ^ d[i]}});
        end
        return c;
    endfunction

    always_ff @(posedge tx_clk or negedge rst_n) begin
        if (!rst_n) begin
            crc <= CRC_INIT;
        end else if (clear) begin
            crc <= CRC_INIT;
        end else if (enable) begin
            crc <= crc_byte(crc, data);
        end
    end

    assign fcs = ~crc;

endmodule

`default_nettype wire

// ==== tx_framer/tx_framer.sv ====
`timescale 1ns/10ps
`default_nettype none

module tx_framer
    import gmii_line_pkg::*;
(
    input  wire                tx_clk,
    input  wire                rst_n,
    byte_stream_if.sink        pay_bs,
    byte_stream_if.sink        pause_bs,
    output logic [BYTE_W-1:0]  gmii_txd,
    output logic               gmii_tx_en
);

    tx_state_e         state;
    logic [3:0]        cnt;
    logic              sel_pause;

    logic              in_valid;
    logic [BYTE_W-1:0] in_data;
    logic              in_last;
    logic              take;
    logic [31:0]       fcs;

    // winner of the last arbitration owns the body
    assign in_valid = sel_pause ? pause_bs.valid : pay_bs.valid;
    assign in_data  = sel_pause ? pause_bs.data  : pay_bs.data;
    assign in_last  = sel_pause ? pause_bs.last  : pay_bs.last;

    assign pause_bs.ready = (state == BODY) && sel_pause;
    assign pay_bs.ready   = (state == BODY) && !sel_pause;

    assign take = (state == BODY) && in_valid;

    crc32_engine u_crc (
        .tx_clk (tx_clk),
        .rst_n  (rst_n),
        .clear  (state == IDLE),
        .enable (take),
        .data   (in_data),
        .fcs    (fcs)
    );

    always_ff @(posedge tx_clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= IDLE;
            cnt        <= 4'd0;
            sel_pause  <= 1'b0;
            gmii_txd   <= '0;
            gmii_tx_en <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    gmii_txd   <= '0;
                    gmii_tx_en <= 1'b0;
                    cnt        <= 4'd0;
                    // pause frames go first
                    if (pause_bs.valid) begin
                        sel_pause <= 1'b1;
                        state     <= PREAMBLE;
                    end else if (pay_bs.valid) begin
                        sel_pause <= 1'b0;
                        state     <= PREAMBLE;
                    end
                end
                PREAMBLE: begin
                    gmii_txd   <= PREAMBLE_BYTE;
                    gmii_tx_en <= 1'b1;
                    if (cnt == 4'(PREAMBLE_LEN - 1)) begin
                        cnt   <= 4'd0;
                        state <= SFD;
                    end else begin
                        cnt <= cnt + 4'd1;
                    end
                end
                SFD: begin
                    gmii_txd   <= SFD_BYTE;
                    gmii_tx_en <= 1'b1;
                    state      <= BODY;
                end
                BODY: begin
                    gmii_txd   <= in_data;
                    gmii_tx_en <= take;
                    if (take && in_last) begin
                        state <= FCS;
                    end
                end
                FCS: begin
                    // low byte of the complemented crc first
                    gmii_txd   <= fcs[{cnt[1:0], 3'b000} +: 8];
                    gmii_tx_en <= 1'b1;
                    if (cnt == 4'(FCS_LEN - 1)) begin
                        cnt   <= 4'd0;
                        state <= GAP;
                    end else begin
                        cnt <= cnt + 4'd1;
                    end
                end
                GAP: begin
                    gmii_txd   <= '0;
                    gmii_tx_en <= 1'b0;
                    if (cnt == 4'(IPG_CYCLES - 1)) begin
                        cnt   <= 4'd0;
                        state <= IDLE;
                    end else begin
                        cnt <= cnt + 4'd1;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== logic/payload_buffer.sv ====
`timescale 1ns/10ps
`default_nettype none

module payload_buffer
    import mac_frame_pkg::*;
(
    input  wire                tx_clk,
    input  wire                rst_n,
    input  wire                word_valid,
    input  wire  [WORD_W-1:0]  word_data,
    input  wire                word_last,
    input  byte_count_t        word_bytes,
    output logic               word_credit,
    byte_stream_if.source      bs
);

    logic [WORD_W-1:0]    mem_data  [BUF_WORDS];
    logic                 mem_last  [BUF_WORDS];
    byte_count_t          mem_bytes [BUF_WORDS];

    logic [BUF_PTR_W-1:0] wr_ptr;
    logic [BUF_PTR_W-1:0] rd_ptr;
    logic [BUF_CNT_W-1:0] frame_cnt;
    logic [2:0]           byte_idx;

    logic [WORD_W-1:0]    head_data;
    logic                 head_last;
    byte_count_t          head_bytes;
    logic                 xfer;
    logic                 word_end;
    logic                 frame_in;
    logic                 frame_out;

    // host credit already guarantees a free slot
    always_ff @(posedge tx_clk) begin
        if (word_valid) begin
            mem_data[wr_ptr]  <= word_data;
            mem_last[wr_ptr]  <= word_last;
            mem_bytes[wr_ptr] <= word_bytes;
        end
    end

    assign head_data  = mem_data[rd_ptr];
    assign head_last  = mem_last[rd_ptr];
    assign head_bytes = mem_bytes[rd_ptr];

    // only whole frames are offered
    assign bs.valid = (frame_cnt != '0);
    assign bs.data  = head_data[{byte_idx, 3'b000} +: 8];
    assign bs.last  = head_last && ({1'b0, byte_idx} + 4'd1 == head_bytes);

    assign xfer      = bs.valid && bs.ready;
    assign word_end  = bs.last || (byte_idx == 3'(WORD_BYTES - 1));
    assign frame_in  = word_valid && word_last;
    assign frame_out = xfer && bs.last;

    always_ff @(posedge tx_clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            frame_cnt   <= '0;
            byte_idx    <= 3'd0;
            word_credit <= 1'b0;
        end else begin
            word_credit <= xfer && word_end;
            if (word_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (xfer) begin
                if (word_end) begin
                    rd_ptr   <= rd_ptr + 1'b1;
                    byte_idx <= 3'd0;
                end else begin
                    byte_idx <= byte_idx + 3'd1;
                end
            end
            if (frame_in && !frame_out) begin
                frame_cnt <= frame_cnt + 1'b1;
            end else if (frame_out && !frame_in) begin
                frame_cnt <= frame_cnt - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/pause_builder.sv ====
`timescale 1ns/10ps
`default_nettype none

module pause_builder
    import mac_frame_pkg::*;
(
    input  wire         tx_clk,
    input  wire         rst_n,
    input  wire         pause_req,
    input  wire  [47:0] pause_src_addr,
    input  wire  [15:0] pause_quanta,
    output logic        pause_sent,
    byte_stream_if.source bs
);

    logic                         pending;
    logic [PAUSE_IDX_W-1:0]       idx;
    logic [PAUSE_HDR_LEN*8-1:0]   hdr;
    logic [PAUSE_HDR_LEN*8-1:0]   hdr_shifted;
    logic                         xfer;

    assign hdr = {PAUSE_DA, pause_src_addr, PAUSE_ETHERTYPE, PAUSE_OPCODE, pause_quanta};

    // shifting past the header yields the zero padding
    assign hdr_shifted = hdr << {idx, 3'b000};

    assign bs.valid = pending;
    assign bs.data  = hdr_shifted[PAUSE_HDR_LEN*8-1 -: 8];
    assign bs.last  = (idx == PAUSE_IDX_W'(PAUSE_BODY_LEN - 1));

    assign xfer       = bs.valid && bs.ready;
    assign pause_sent = xfer && bs.last;

    always_ff @(posedge tx_clk or negedge rst_n) begin
        if (!rst_n) begin
            pending <= 1'b0;
            idx     <= '0;
        end else begin
            if (pause_req) begin
                pending <= 1'b1;
            end else if (pause_sent) begin
                pending <= 1'b0;
            end
            if (xfer) begin
                idx <= bs.last ? '0 : idx + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/gmii_tx_mac.sv ====
`timescale 1ns/10ps
`default_nettype none

module gmii_tx_mac
    import mac_frame_pkg::*;
(
    input  wire               tx_clk,
    input  wire               rst_n,

    input  wire               word_valid,
    input  wire  [WORD_W-1:0] word_data,
    input  wire               word_last,
    input  byte_count_t       word_bytes,
    output logic              word_credit,

    input  wire               pause_req,
    input  wire  [47:0]       pause_src_addr,
    input  wire  [15:0]       pause_quanta,
    output logic              pause_sent,

    output logic [7:0]        gmii_txd,
    output logic              gmii_tx_en
);

    byte_stream_if pay_bs ();
    byte_stream_if pause_bs ();

    payload_buffer u_payload_buffer (
        .tx_clk      (tx_clk),
        .rst_n       (rst_n),
        .word_valid  (word_valid),
        .word_data   (word_data),
        .word_last   (word_last),
        .word_bytes  (word_bytes),
        .word_credit (word_credit),
        .bs          (pay_bs)
    );

    pause_builder u_pause_builder (
        .tx_clk         (tx_clk),
        .rst_n          (rst_n),
        .pause_req      (pause_req),
        .pause_src_addr (pause_src_addr),
        .pause_quanta   (pause_quanta),
        .pause_sent     (pause_sent),
        .bs             (pause_bs)
    );

    tx_framer u_tx_framer (
        .tx_clk     (tx_clk),
        .rst_n      (rst_n),
        .pay_bs     (pay_bs),
        .pause_bs   (pause_bs),
        .gmii_txd   (gmii_txd),
        .gmii_tx_en (gmii_tx_en)
    );

endmodule

`default_nettype wire

// ==== test/gmii_tx_mac_properties.sv ====
`timescale 1ns/10ps
`default_nettype none

module gmii_tx_mac_properties
    import gmii_line_pkg::*;
(
    input wire              tx_clk,
    input wire              rst_n,
    input wire [BYTE_W-1:0] gmii_txd,
    input wire              gmii_tx_en,
    input wire              pay_valid,
    input wire              pay_ready,
    input wire              pause_valid,
    input wire              pause_ready
);

    logic [4:0] low_run;
    logic       sent_once;

    // consecutive idle cycles, saturating
    always_ff @(posedge tx_clk or negedge rst_n) begin
        if (!rst_n) begin
            low_run   <= '0;
            sent_once <= 1'b0;
        end else if (gmii_tx_en) begin
            low_run   <= '0;
            sent_once <= 1'b1;
        end else if (low_run != 5'd31) begin
            low_run <= low_run + 5'd1;
        end
    end

    first_byte_preamble: assert property (@(posedge tx_clk) disable iff (!rst_n)
        $rose(gmii_tx_en) |-> gmii_txd == PREAMBLE_BYTE)
        else $error("frame does not start with a preamble byte");

    gap_after_frame: assert property (@(posedge tx_clk) disable iff (!rst_n)
        $rose(gmii_tx_en) && sent_once |-> low_run >= 5'(IPG_CYCLES))
        else $error("tx_en came back before the inter-packet gap ended");

    pay_ready_valid: assert property (@(posedge tx_clk) disable iff (!rst_n)
        pay_ready |-> pay_valid)
        else $error("payload source had no byte while ready was high");

    pause_ready_valid: assert property (@(posedge tx_clk) disable iff (!rst_n)
        pause_ready |-> pause_valid)
        else $error("pause source had no byte while ready was high");

endmodule

`default_nettype wire

// ==== test/gmii_tx_mac_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module gmii_tx_mac_tb
    import gmii_line_pkg::*, mac_frame_pkg::*;
();

    logic              tx_clk;
    logic              rst_n;
    logic              word_valid;
    logic [WORD_W-1:0] word_data;
    logic              word_last;
    byte_count_t       word_bytes;
    logic              word_credit;
    logic              pause_req;
    logic [47:0]       pause_src_addr;
    logic [15:0]       pause_quanta;
    logic              pause_sent;
    logic [7:0]        gmii_txd;
    logic              gmii_tx_en;

    // expected line bytes of all queued frames
    logic [7:0] exp_bytes[$];
    int         exp_len[$];
    string      exp_name[$];
    logic [7:0] act_bytes[$];

    int words_sent   = 0;
    int credits_back = 0;
    int pause_reqs   = 0;
    int pause_acks   = 0;
    int low_run      = 0;
    bit seen_frame   = 1'b0;

    gmii_tx_mac DUT (
        .tx_clk         (tx_clk),
        .rst_n          (rst_n),
        .word_valid     (word_valid),
        .word_data      (word_data),
        .word_last      (word_last),
        .word_bytes     (word_bytes),
        .word_credit    (word_credit),
        .pause_req      (pause_req),
        .pause_src_addr (pause_src_addr),
        .pause_quanta   (pause_quanta),
        .pause_sent     (pause_sent),
        .gmii_txd       (gmii_txd),
        .gmii_tx_en     (gmii_tx_en)
    );

    bind tx_framer gmii_tx_mac_properties u_props (
        .tx_clk      (tx_clk),
        .rst_n       (rst_n),
        .gmii_txd    (gmii_txd),
        .gmii_tx_en  (gmii_tx_en),
        .pay_valid   (pay_bs.valid),
        .pay_ready   (pay_bs.ready),
        .pause_valid (pause_bs.valid),
        .pause_ready (pause_bs.ready)
    );

    initial begin
        tx_clk = 1'b0;
        forever #50 tx_clk = ~tx_clk;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("SOME TESTS FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    // msb-first register fed lsb-first and mirrored onto the line
    function automatic logic [31:0] ether_fcs(input logic [7:0] body[$]);
        logic [31:0] c;
        logic [31:0] r;
        logic        fb;
        c = 32'hFFFF_FFFF;
        foreach (body[i]) begin
            for (int b = 0; b < 8; b++) begin
                fb = c[31] ^ body[i][b];
                c  = {c[30:0], 1'b0} ^ (fb ? 32'h04C1_1DB7 : 32'h0);
            end
        end
        c = ~c;
        for (int k = 0; k < 32; k++) begin
            r[k] = c[31-k];
        end
        return r;
    endfunction

    task automatic add_expected(input string name, input logic [7:0] body[$]);
        logic [31:0] fcs;
        fcs = ether_fcs(body);
        repeat (PREAMBLE_LEN) exp_bytes.push_back(8'h55);
        exp_bytes.push_back(8'hD5);
        foreach (body[i]) exp_bytes.push_back(body[i]);
        for (int k = 0; k < 4; k++) exp_bytes.push_back(fcs[8*k +: 8]);
        exp_len.push_back(8 + body.size() + 4);
        exp_name.push_back(name);
    endtask

    task automatic expect_data(input string name, input int len, input int first);
        logic [7:0] body[$];
        for (int i = 0; i < len; i++) body.push_back(8'((first + i) % 256));
        add_expected(name, body);
    endtask

    task automatic expect_pause(input string name);
        logic [7:0]   body[$];
        logic [143:0] hdr;
        hdr = {48'h0180_C200_0001, pause_src_addr, 16'h8808, 16'h0001, pause_quanta};
        for (int i = 0; i < 18; i++) body.push_back(hdr[143 - 8*i -: 8]);
        while (body.size() < 60) body.push_back(8'h00);
        add_expected(name, body);
    endtask

    task automatic wait_line_idle();
        int t;
        t = 0;
        while (exp_len.size() != 0 || gmii_tx_en) begin
            @(negedge tx_clk);
            t++;
            if (t > 20000) fail_run("timeout waiting for the line to go idle");
        end
    endtask

    // host side sends one word per credit
    task automatic send_frame(input int len, input int first, input bit with_pause);
        int                nw;
        int                gap;
        int                t;
        logic [WORD_W-1:0] w;
        nw = (len + WORD_BYTES - 1) / WORD_BYTES;
        for (int k = 0; k < nw; k++) begin
            gap = int'($urandom % 3);
            repeat (gap) begin
                @(negedge tx_clk);
                word_valid = 1'b0;
            end
            t = 0;
            while (words_sent - credits_back >= BUF_WORDS) begin
                @(negedge tx_clk);
                word_valid = 1'b0;
                t++;
                if (t > 5000) fail_run("timeout waiting for a word credit");
            end
            for (int b = 0; b < WORD_BYTES; b++) begin
                w[8*b +: 8] = 8'((first + k*WORD_BYTES + b) % 256);
            end
            @(negedge tx_clk);
            word_valid = 1'b1;
            word_data  = w;
            word_last  = (k == nw - 1);
            word_bytes = byte_count_t'((k == nw - 1) ? len - k*WORD_BYTES : WORD_BYTES);
            pause_req  = with_pause && (k == nw - 1);
            words_sent++;
        end
        @(negedge tx_clk);
        word_valid = 1'b0;
        word_last  = 1'b0;
        pause_req  = 1'b0;
    endtask

    task automatic check_frame();
        int         len;
        string      name;
        logic [7:0] eb;
        assert (exp_len.size() != 0)
            else fail_run("a frame appeared on the line with none expected");
        len  = exp_len.pop_front();
        name = exp_name.pop_front();
        assert (act_bytes.size() == len)
            else fail_run($sformatf("Mismatch in %s length: expected %0d, actual %0d",
                                    name, len, act_bytes.size()));
        foreach (act_bytes[i]) begin
            eb = exp_bytes.pop_front();
            assert (act_bytes[i] == eb)
                else fail_run($sformatf("Mismatch in %s byte %0d: expected %02h, actual %02h",
                                        name, i, eb, act_bytes[i]));
        end
        act_bytes.delete();
    endtask

    // line monitor and credit bookkeeping
    always @(posedge tx_clk) begin
        if (word_credit) credits_back++;
        if (pause_sent) pause_acks++;
        assert (words_sent - credits_back >= 0 && words_sent - credits_back <= BUF_WORDS)
            else fail_run("outstanding host credits left the range 0 to BUF_WORDS");
        if (gmii_tx_en) begin
            if (act_bytes.size() == 0) begin
                assert (!seen_frame || low_run >= IPG_CYCLES)
                    else fail_run($sformatf("gap of %0d idle cycles between frames is too short",
                                            low_run));
            end
            act_bytes.push_back(gmii_txd);
            low_run = 0;
        end else begin
            if (act_bytes.size() != 0) begin
                check_frame();
                seen_frame = 1'b1;
            end
            low_run++;
        end
    end

    initial begin
        int          fd;
        int          n;
        int          len;
        int          first;
        int          quanta;
        string       line;
        void'($urandom(19774));
        rst_n          = 1'b0;
        word_valid     = 1'b0;
        word_data      = '0;
        word_last      = 1'b0;
        word_bytes     = byte_count_t'(8);
        pause_req      = 1'b0;
        pause_src_addr = 48'h02_1A_2B_3C_4D_5E;
        pause_quanta   = 16'h0000;
        repeat (5) @(negedge tx_clk);
        rst_n = 1'b1;

        fd = $fopen("test/gmii_tx_mac_testdata.txt", "r");
        if (fd == 0) fail_run("cannot open test/gmii_tx_mac_testdata.txt");
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n == 0 || line.len() < 2 || line.getc(0) == "#") continue;
            if (line.getc(0) == "D") begin
                n = $sscanf(line, "D %d %h", len, first);
                if (n != 2 || len < 1 || len > MAX_FRAME_BYTES) begin
                    fail_run("malformed data frame record in the data file");
                end
                expect_data($sformatf("D%0d", len), len, first);
                send_frame(len, first, 1'b0);
            end else if (line.getc(0) == "P") begin
                n = $sscanf(line, "P %h", quanta);
                if (n != 1) fail_run("malformed pause record in the data file");
                wait_line_idle();
                pause_quanta = 16'(quanta);
                expect_pause($sformatf("P%04h", quanta));
                @(negedge tx_clk);
                pause_req = 1'b1;
                pause_reqs++;
                @(negedge tx_clk);
                pause_req = 1'b0;
            end else if (line.getc(0) == "B") begin
                n = $sscanf(line, "B %d %h %h", len, first, quanta);
                if (n != 3 || len < 1 || len > MAX_FRAME_BYTES) begin
                    fail_run("malformed combined record in the data file");
                end
                wait_line_idle();
                pause_quanta = 16'(quanta);
                // pause jumps ahead of the data frame
                expect_pause($sformatf("B%0d pause %04h", len, quanta));
                expect_data($sformatf("B%0d data", len), len, first);
                pause_reqs++;
                send_frame(len, first, 1'b1);
            end else begin
                fail_run("unknown record kind in the data file");
            end
        end
        $fclose(fd);

        wait_line_idle();
        assert (pause_acks == pause_reqs)
            else fail_run($sformatf("Mismatch in pause_sent count: expected %0d, actual %0d",
                                    pause_reqs, pause_acks));
        assert (credits_back == words_sent)
            else fail_run($sformatf("Mismatch in credit total: expected %0d, actual %0d",
                                    words_sent, credits_back));
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== test/gmii_tx_mac_testdata.txt ====
# columns: kind, body length in bytes (decimal), first payload byte (hex), pause quanta (hex)
# kinds: D data frame, P pause frame, B pause request on the last word of a data frame
D 60 00
D 64 a5
D 61 10
D 127 ff
D 200 3c
D 199 80
D 200 01
D 200 02
D 200 03
P 0100
D 75 7e
P 0000
B 96 20 ffff
D 150 c4
B 63 55 0abc
D 183 09
D 200 e0
D 200 f1
P 1234
D 66 40

// ==== sim.f ====
common/gmii_line_pkg.sv
common/mac_frame_pkg.sv
common/byte_stream_if.sv
tx_framer/crc32_engine.sv
tx_framer/tx_framer.sv
logic/payload_buffer.sv
logic/pause_builder.sv
logic/gmii_tx_mac.sv
test/gmii_tx_mac_properties.sv
test/gmii_tx_mac_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the gmii tx mac testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps -j 0 \
    --top-module gmii_tx_mac_tb -o gmii_tx_mac_sim -f sim.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/gmii_tx_mac_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "ALL TESTS PASSED"; then
    exit 0
fi
exit 1
